// File: arcade_consts.svh
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

`define KEY_LEFT        8'h6B // Cursor left.
`define KEY_RIGHT       8'h74 // Cursor right.
`define KEY_COIN        8'h76 // ESC.
`define KEY_ONE         8'h05 // F1.
`define KEY_TWO         8'h06 // F2.
`define KEY_FIRE        8'h29 // Space.

// Register map, byte addresses.
`define REG_STATUS      4'h0
`define REG_CONTROLS    4'h4

`define OVL_TOP_LINE    9'd16  // First line of the white band.
`define OVL_BOTTOM_LINE 9'd200 // First line of the green band.

`define GAME_RST_CYCLES 5'd16  // Soft reset pulse length.

`endif

// File: axil_pkg.sv
`default_nettype none

package axil_pkg;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_t;

	// One copy per channel, write and read run independently.
	typedef enum logic {
		st_idle = 1'b0, // Ready to accept.
		st_resp = 1'b1  // Response valid, waiting for ready.
	} axil_state_t;

endpackage

`default_nettype wire

// File: arcade_io_pkg.sv
`default_nettype none

package arcade_io_pkg;

	typedef enum logic [2:0] {
		act_none,
		act_left,
		act_right,
		act_coin,
		act_one,
		act_two,
		act_fire
	} key_action_t;

	// Encoded as {r, g, b}.
	typedef enum logic [2:0] {
		col_black = 3'b000,
		col_red   = 3'b100,
		col_green = 3'b010,
		col_white = 3'b111
	} ovl_color_t;

	// Merged controls, active high, left in bit 0.
	typedef struct packed {
		logic two;
		logic one;
		logic coin;
		logic fire;
		logic right;
		logic left;
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: game_buttons_if.sv
`timescale 1ns/1ps
`default_nettype none

interface game_buttons_if;
	logic left;  // Held keyboard buttons, active high.
	logic right;
	logic fire;
	logic coin;
	logic one;
	logic two;

	modport source (output left, right, fire, coin, one, two);
	modport sink (input left, right, fire, coin, one, two);
endinterface

interface config_if;
	logic [1:0] scanlines;
	logic       overlay_off;
	logic       reset_req;   // One cycle pulse.
	logic [5:0] controls;    // Merged state for readback.

	modport regs (output scanlines, overlay_off, reset_req, input controls);
	modport merge (input reset_req, output controls);
	modport video (input overlay_off);
endinterface

`default_nettype wire

// File: key_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module key_decode (
	input  logic           clk_sys,
	input  logic           rst,
	input  logic           key_strobe,
	input  logic           key_pressed,
	input  logic [7:0]     key_code,
	game_buttons_if.source btn
);
	import arcade_io_pkg::*;

	key_action_t action;

	always_comb begin
		case (key_code)
			`KEY_LEFT:  action = act_left;
			`KEY_RIGHT: action = act_right;
			`KEY_COIN:  action = act_coin;
			`KEY_ONE:   action = act_one;
			`KEY_TWO:   action = act_two;
			`KEY_FIRE:  action = act_fire;
			default:    action = act_none; // Unmapped key.
		endcase
	end

	// Each key keeps its own level, so presses overlap freely.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			btn.left  <= 1'b0;
			btn.right <= 1'b0;
			btn.fire  <= 1'b0;
			btn.coin  <= 1'b0;
			btn.one   <= 1'b0;
			btn.two   <= 1'b0;
		end else if (key_strobe) begin
			case (action)
				act_left:  btn.left  <= key_pressed;
				act_right: btn.right <= key_pressed;
				act_coin:  btn.coin  <= key_pressed;
				act_one:   btn.one   <= key_pressed;
				act_two:   btn.two   <= key_pressed;
				act_fire:  btn.fire  <= key_pressed;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: control_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module control_merge (
	input  logic         clk_sys,
	input  logic         rst,
	game_buttons_if.sink btn,
	config_if.merge      cfg,
	input  logic [7:0]   joystick_0,
	input  logic [7:0]   joystick_1,
	output logic         move_left_n,
	output logic         move_right_n,
	output logic         fire_n,
	output logic         sel1_n,
	output logic         sel2_n,
	output logic         coin,
	output logic         game_rst_n
);
	import arcade_io_pkg::*;

	ctrl_state_t ctrl_q;
	logic [4:0]  rst_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q.left  <= btn.left | joystick_0[1] | joystick_1[1];
			ctrl_q.right <= btn.right | joystick_0[0] | joystick_1[0];
			ctrl_q.fire  <= btn.fire | joystick_0[4] | joystick_1[4];
			ctrl_q.coin  <= btn.coin;
			ctrl_q.one   <= btn.one;
			ctrl_q.two   <= btn.two;
		end
	end

	assign move_left_n  = ~ctrl_q.left; // Core inputs are active low.
	assign move_right_n = ~ctrl_q.right;
	assign fire_n       = ~ctrl_q.fire;
	assign sel1_n       = ~ctrl_q.one;
	assign sel2_n       = ~ctrl_q.two;
	assign coin         = ctrl_q.coin;  // Coin stays active high.
	assign cfg.controls = ctrl_q;

	// Game reset stretcher, low for rst_cnt + 1 cycles after a trigger.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rst_cnt    <= 5'd2; // Short tail after board reset.
			game_rst_n <= 1'b0;
		end else if (cfg.reset_req) begin
			rst_cnt    <= `GAME_RST_CYCLES - 5'd1;
			game_rst_n <= 1'b0;
		end else if (rst_cnt != 5'd0) begin
			rst_cnt    <= rst_cnt - 5'd1;
			game_rst_n <= 1'b0;
		end else begin
			game_rst_n <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: config_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module config_regs (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic [3:0]          awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic                wvalid,
	output logic                wready,
	output axil_pkg::axil_resp_t bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [3:0]          araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output axil_pkg::axil_resp_t rresp,
	output logic                rvalid,
	input  logic                rready,
	config_if.regs              cfg
);
	import axil_pkg::*;

	axil_state_t wr_state;
	axil_state_t rd_state;
	logic        wr_go;
	logic        rd_go;

	// Address and data are taken together in one cycle.
	assign wr_go   = (wr_state == st_idle) && awvalid && wvalid;
	assign awready = wr_go;
	assign wready  = wr_go;
	assign bvalid  = (wr_state == st_resp);

	assign arready = (rd_state == st_idle);
	assign rd_go   = arready && arvalid;
	assign rvalid  = (rd_state == st_resp);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_state        <= st_idle;
			cfg.scanlines   <= 2'd0;
			cfg.overlay_off <= 1'b0;
			cfg.reset_req   <= 1'b0;
		end else begin
			cfg.reset_req <= 1'b0;
			case (wr_state)
				st_idle: begin
					if (wr_go) begin
						wr_state <= st_resp;
						if (awaddr == `REG_STATUS) begin
							cfg.scanlines   <= wdata[4:3];
							cfg.overlay_off <= wdata[5];
							cfg.reset_req   <= wdata[6]; // Self clearing.
						end
					end
				end
				st_resp: begin
					if (bready)
						wr_state <= st_idle;
				end
				default: wr_state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_go) begin
			if (awaddr == `REG_STATUS || awaddr == `REG_CONTROLS)
				bresp <= resp_okay;
			else
				bresp <= resp_slverr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rd_state <= st_idle;
		end else begin
			case (rd_state)
				st_idle: if (rd_go) rd_state <= st_resp;
				st_resp: if (rready) rd_state <= st_idle;
				default: rd_state <= st_idle;
			endcase
		end
	end

	// Read data is captured at acceptance and held through the stall.
	always_ff @(posedge clk_sys) begin
		if (rd_go) begin
			case (araddr)
				`REG_STATUS: begin
					rdata <= {25'd0, 1'b0, cfg.overlay_off, cfg.scanlines, 3'd0};
					rresp <= resp_okay;
				end
				`REG_CONTROLS: begin
					rdata <= {26'd0, cfg.controls};
					rresp <= resp_okay;
				end
				default: begin
					rdata <= 32'd0;
					rresp <= resp_slverr;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: overlay_color.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module overlay_color (
	input  logic    clk_sys,
	input  logic    rst,
	input  logic    video,
	input  logic    hsync_in,
	input  logic    vsync_in,
	config_if.video cfg,
	output logic    video_r,
	output logic    video_g,
	output logic    video_b,
	output logic    hsync,
	output logic    vsync
);
	import arcade_io_pkg::*;

	logic [8:0] line_cnt;
	ovl_color_t pix_color;
	ovl_color_t color_q;

	// hsync is the delayed copy of hsync_in, so it doubles as the edge detector.
	always_ff @(posedge clk_sys) begin
		if (rst || vsync_in)
			line_cnt <= 9'd0;
		else if (hsync_in && !hsync)
			line_cnt <= line_cnt + 9'd1;
	end

	always_comb begin
		if (!video)
			pix_color = col_black;
		else if (cfg.overlay_off)
			pix_color = col_white;
		else if (line_cnt < `OVL_TOP_LINE)
			pix_color = col_red;   // Top band.
		else if (line_cnt >= `OVL_BOTTOM_LINE)
			pix_color = col_green; // Bottom band.
		else
			pix_color = col_white;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			color_q <= col_black;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
		end else begin
			color_q <= pix_color;
			hsync   <= hsync_in; // Keeps sync aligned with colour.
			vsync   <= vsync_in;
		end
	end

	assign {video_r, video_g, video_b} = color_q;

endmodule

`default_nettype wire

// File: arcade_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module arcade_io_top (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                key_strobe,
	input  logic                key_pressed,
	input  logic [7:0]          key_code,
	input  logic [7:0]          joystick_0,
	input  logic [7:0]          joystick_1,
	output logic                move_left_n,
	output logic                move_right_n,
	output logic                fire_n,
	output logic                sel1_n,
	output logic                sel2_n,
	output logic                coin,
	output logic                game_rst_n,
	input  logic [3:0]          awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic                wvalid,
	output logic                wready,
	output axil_pkg::axil_resp_t bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [3:0]          araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output axil_pkg::axil_resp_t rresp,
	output logic                rvalid,
	input  logic                rready,
	input  logic                video,
	input  logic                hsync_in,
	input  logic                vsync_in,
	output logic                video_r,
	output logic                video_g,
	output logic                video_b,
	output logic                hsync,
	output logic                vsync,
	output logic [1:0]          scanlines
);

	game_buttons_if btn_bus ();
	config_if       cfg_bus ();

	assign scanlines = cfg_bus.scanlines; // Goes on to the scan doubler.

	key_decode u_key_decode (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.btn         (btn_bus.source)
	);

	control_merge u_control_merge (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.btn          (btn_bus.sink),
		.cfg          (cfg_bus.merge),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.move_left_n  (move_left_n),
		.move_right_n (move_right_n),
		.fire_n       (fire_n),
		.sel1_n       (sel1_n),
		.sel2_n       (sel2_n),
		.coin         (coin),
		.game_rst_n   (game_rst_n)
	);

	config_regs u_config_regs (
		.clk_sys (clk_sys),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.cfg     (cfg_bus.regs)
	);

	overlay_color u_overlay_color (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.video    (video),
		.hsync_in (hsync_in),
		.vsync_in (vsync_in),
		.cfg      (cfg_bus.video),
		.video_r  (video_r),
		.video_g  (video_g),
		.video_b  (video_b),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

`default_nettype wire

// File: arcade_io_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module arcade_io_properties (
	input logic                 clk_sys,
	input logic                 rst,
	input logic                 key_strobe,
	input logic                 key_pressed,
	input logic [7:0]           key_code,
	input logic [7:0]           joystick_0,
	input logic [7:0]           joystick_1,
	input logic                 move_left_n,
	input logic                 move_right_n,
	input logic                 fire_n,
	input logic                 sel1_n,
	input logic                 sel2_n,
	input logic                 coin,
	input logic                 game_rst_n,
	input logic [3:0]           awaddr,
	input logic                 awvalid,
	input logic                 awready,
	input logic [31:0]          wdata,
	input logic                 wvalid,
	input logic                 wready,
	input axil_pkg::axil_resp_t bresp,
	input logic                 bvalid,
	input logic                 bready,
	input logic [3:0]           araddr,
	input logic                 arvalid,
	input logic                 arready,
	input logic [31:0]          rdata,
	input axil_pkg::axil_resp_t rresp,
	input logic                 rvalid,
	input logic                 rready,
	input logic                 video,
	input logic                 hsync_in,
	input logic                 vsync_in,
	input logic                 video_r,
	input logic                 video_g,
	input logic                 video_b,
	input logic                 hsync,
	input logic                 vsync,
	input logic [1:0]           scanlines,
	input logic                 overlay_off,
	input logic [5:0]           btn_vec     // {two, one, coin, fire, right, left}.
);
	import axil_pkg::*;
	import arcade_io_pkg::*;

	int unsigned fail_count = 0;

	logic [5:0]  key_mask;
	logic [5:0]  next_btn;
	logic [5:0]  ctrl_out;
	logic [5:0]  merged;
	logic [31:0] exp_rdata;
	axil_resp_t  exp_rresp;
	logic [8:0]  line_model;
	logic        hs_prev;
	ovl_color_t  exp_color;

	function automatic logic [5:0] key_bit(input logic [7:0] code);
		case (code)
			`KEY_LEFT:  return 6'b000001;
			`KEY_RIGHT: return 6'b000010;
			`KEY_FIRE:  return 6'b000100;
			`KEY_COIN:  return 6'b001000;
			`KEY_ONE:   return 6'b010000;
			`KEY_TWO:   return 6'b100000;
			default:    return 6'b000000; // No button for this code.
		endcase
	endfunction

	function automatic void note_failure(input string what);
		$error("%s", what);
		fail_count++;
	endfunction

	assign key_mask = key_bit(key_code);
	assign next_btn = !key_strobe ? btn_vec
		: (key_pressed ? (btn_vec | key_mask) : (btn_vec & ~key_mask));
	assign ctrl_out = {!sel2_n, !sel1_n, coin, !fire_n, !move_right_n, !move_left_n};
	assign merged   = {btn_vec[5:3], btn_vec[2] | joystick_0[4] | joystick_1[4],
		btn_vec[1] | joystick_0[0] | joystick_1[0], btn_vec[0] | joystick_0[1] | joystick_1[1]};

	always_comb begin
		exp_rdata = 32'd0;
		exp_rresp = resp_slverr;
		if (araddr == `REG_STATUS) begin
			exp_rdata = {26'd0, overlay_off, scanlines, 3'd0}; // Bit 6 reads as 0.
			exp_rresp = resp_okay;
		end else if (araddr == `REG_CONTROLS) begin
			exp_rdata = {26'd0, ctrl_out};
			exp_rresp = resp_okay;
		end
	end

	// Reference line count, cleared by vsync and stepped on hsync rising.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_prev    <= 1'b0;
			line_model <= 9'd0;
		end else begin
			hs_prev <= hsync_in;
			if (vsync_in)
				line_model <= 9'd0;
			else if (hsync_in && !hs_prev)
				line_model <= line_model + 9'd1;
		end
	end

	always_comb begin
		if (!video)
			exp_color = col_black;
		else if (overlay_off || (line_model >= `OVL_TOP_LINE && line_model < `OVL_BOTTOM_LINE))
			exp_color = col_white;
		else if (line_model < `OVL_TOP_LINE)
			exp_color = col_red;
		else
			exp_color = col_green;
	end

	a_keys: assert property (@(posedge clk_sys) disable iff (rst)
		1'b1 |=> btn_vec == $past(next_btn))
		else note_failure("Held buttons do not follow the key events.");

	a_merge: assert property (@(posedge clk_sys) disable iff (rst)
		1'b1 |=> ctrl_out == $past(merged))
		else note_failure("Game controls do not follow the merge rules.");

	a_write_accept: assert property (@(posedge clk_sys) disable iff (rst)
		(awready || wready) |-> (awready && wready && awvalid && wvalid) ##1 (bvalid && !awready))
		else note_failure("Write handshake broke the AXI4-Lite rules.");

	a_b_hold: assert property (@(posedge clk_sys) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else note_failure("Write response dropped during a stall.");

	a_ar_idle: assert property (@(posedge clk_sys) disable iff (rst) arready == !rvalid)
		else note_failure("arready is not high exactly when the read channel is idle.");

	a_read_data: assert property (@(posedge clk_sys) disable iff (rst)
		arready && arvalid |=> rvalid && rdata == $past(exp_rdata) && rresp == $past(exp_rresp))
		else note_failure("Read response carries the wrong data or response code.");

	a_r_hold: assert property (@(posedge clk_sys) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else note_failure("Read response dropped during a stall.");

	a_wr_status: assert property (@(posedge clk_sys) disable iff (rst)
		awready && awaddr == `REG_STATUS |=> bresp == resp_okay
			&& scanlines == $past(wdata[4:3]) && overlay_off == $past(wdata[5]))
		else note_failure("Status write was not stored.");

	a_wr_other: assert property (@(posedge clk_sys) disable iff (rst)
		awready && awaddr != `REG_STATUS |=> $stable(scanlines) && $stable(overlay_off)
			&& bresp == (($past(awaddr) == `REG_CONTROLS) ? resp_okay : resp_slverr))
		else note_failure("Write to a non-status address misbehaved.");

	a_game_rst: assert property (@(posedge clk_sys) disable iff (rst)
		awready && awaddr == `REG_STATUS && wdata[6]
			|-> ##2 (!game_rst_n) [*`GAME_RST_CYCLES] ##1 game_rst_n)
		else note_failure("Soft reset pulse has the wrong length.");

	a_after_reset: assert property (@(posedge clk_sys)
		$fell(rst) |-> (!awready && !wready && !bvalid && !rvalid && scanlines == 2'd0
			&& !overlay_off && btn_vec == 6'd0 && move_left_n && move_right_n && fire_n
			&& sel1_n && sel2_n && !coin && !game_rst_n)
			##1 (!game_rst_n) [*2] ##1 game_rst_n)
		else note_failure("Outputs after reset are not at their inactive values.");

	a_color: assert property (@(posedge clk_sys) disable iff (rst)
		1'b1 |=> {video_r, video_g, video_b} == $past(exp_color))
		else note_failure("Overlay colour is wrong for the line band.");

	a_sync: assert property (@(posedge clk_sys) disable iff (rst)
		1'b1 |=> hsync == $past(hsync_in) && vsync == $past(vsync_in))
		else note_failure("Sync outputs are not delayed by one cycle.");

endmodule

bind arcade_io_top arcade_io_properties u_props (
	.overlay_off (cfg_bus.overlay_off),
	.btn_vec     ({btn_bus.two, btn_bus.one, btn_bus.coin, btn_bus.fire, btn_bus.right,
		btn_bus.left}),
	.*
);

`default_nettype wire

// File: tb_arcade_io.sv
`timescale 1ns/1ps
`default_nettype none
`include "arcade_consts.svh"

module tb_arcade_io;
	import axil_pkg::*;

	// The 202 line video frame takes most of the roughly 1200 cycle run.
	localparam int watchdog_cycles = 4000;
	localparam int drive_delay = 10;
	localparam logic [7:0] key_codes [6] = '{`KEY_LEFT, `KEY_RIGHT, `KEY_FIRE,
		`KEY_COIN, `KEY_ONE, `KEY_TWO};

	logic        clk_sys;
	logic        rst;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic        move_left_n;
	logic        move_right_n;
	logic        fire_n;
	logic        sel1_n;
	logic        sel2_n;
	logic        coin;
	logic        game_rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	axil_resp_t  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	axil_resp_t  rresp;
	logic        rvalid;
	logic        rready;
	logic        video;
	logic        hsync_in;
	logic        vsync_in;
	logic        video_r;
	logic        video_g;
	logic        video_b;
	logic        hsync;
	logic        vsync;
	logic [1:0]  scanlines;

	arcade_io_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "Run stopped at %0t ns.", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		assert (got === expected)
		else begin
			$display("error %0t ns %s expected %0h got %0h", $time, name, expected, got);
			stop_with_failure("A value seen by the testbench is wrong.");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#drive_delay;
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		next_cycle();
		key_strobe = 1'b0;
		repeat (2) next_cycle(); // Let the event reach the outputs.
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output axil_resp_t resp);
		int   stall;
		logic done;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		done    = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			done = awready;
			next_cycle();
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		stall   = $urandom % 4;
		repeat (stall) next_cycle(); // bready held low.
		bready = 1'b1;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			done = bvalid;
			resp = bresp;
			next_cycle();
		end
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output axil_resp_t resp);
		int   stall;
		logic done;
		araddr  = addr;
		arvalid = 1'b1;
		done    = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			done = arready;
			next_cycle();
		end
		arvalid = 1'b0;
		stall   = $urandom % 4;
		repeat (stall) next_cycle(); // rready held low.
		rready = 1'b1;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			done = rvalid;
			data = rdata;
			resp = rresp;
			next_cycle();
		end
		rready = 1'b0;
	endtask

	// Four clocks per line with hsync in the first one.
	task automatic video_frame(input int lines);
		vsync_in = 1'b1;
		video    = 1'b0;
		repeat (2) next_cycle();
		vsync_in = 1'b0;
		for (int l = 0; l < lines; l++) begin
			for (int p = 0; p < 4; p++) begin
				hsync_in = (p == 0);
				video    = (p == 2) ? 1'b1 : 1'($urandom); // Every line has a lit pixel.
				next_cycle();
			end
		end
		hsync_in = 1'b0;
		video    = 1'b0;
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		stop_with_failure("Watchdog expired before the tests finished.");
	end

	always @(negedge clk_sys) begin
		if (uut.u_props.fail_count != 0)
			stop_with_failure("A bound assertion on the DUT failed.");
	end

	initial begin
		logic [31:0] data;
		logic [31:0] rd;
		axil_resp_t  resp;
		void'($urandom(32'h58ad2e85));
		rst         = 1'b1;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		awaddr      = 4'h0;
		awvalid     = 1'b0;
		wdata       = 32'd0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = 4'h0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		video       = 1'b0;
		hsync_in    = 1'b0;
		vsync_in    = 1'b0;
		repeat (3) @(posedge clk_sys);
		#drive_delay;
		rst = 1'b0;
		repeat (4) next_cycle(); // Game reset tail.

		for (int i = 0; i < 6; i++)
			key_event(key_codes[i], 1'b1);
		key_event(8'h1C, 1'b1); // Unmapped key.
		for (int i = 0; i < 6; i++)
			key_event(key_codes[i], 1'b0);

		// The first half runs the joysticks without any held key.
		for (int i = 0; i < 60; i++) begin
			if (i == 30) begin
				key_event(`KEY_FIRE, 1'b1);
				key_event(`KEY_LEFT, 1'b1);
			end
			joystick_0 = 8'($urandom);
			joystick_1 = 8'($urandom);
			next_cycle();
		end
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		key_event(`KEY_LEFT, 1'b0);

		repeat (3) begin
			data = $urandom & 32'h0000_0038;
			axi_write(`REG_STATUS, data, resp);
			check_value("bresp", resp_okay, resp);
			axi_read(`REG_STATUS, rd, resp);
			check_value("rdata", data, rd);
			check_value("scanlines", data[4:3], scanlines);
		end
		key_event(`KEY_COIN, 1'b1);
		axi_read(`REG_CONTROLS, rd, resp);
		check_value("rdata", 32'h0000_000C, rd); // Fire and coin held.
		axi_write(`REG_CONTROLS, data ^ 32'h0000_003F, resp);
		check_value("bresp", resp_okay, resp);
		axi_write(4'h8, data ^ 32'h0000_0038, resp);
		check_value("bresp", resp_slverr, resp);
		axi_read(4'hC, rd, resp);
		check_value("rresp", resp_slverr, resp);
		check_value("rdata", 32'd0, rd);
		axi_read(`REG_STATUS, rd, resp);
		check_value("rdata", data, rd);

		axi_write(`REG_STATUS, data | 32'h0000_0040, resp);
		@(negedge clk_sys);
		while (!game_rst_n)
			@(negedge clk_sys);
		next_cycle();
		axi_read(`REG_STATUS, rd, resp);
		check_value("rdata", data, rd);

		axi_write(`REG_STATUS, 32'h0000_0008, resp); // Overlay on.
		video_frame(202);
		axi_write(`REG_STATUS, 32'h0000_0028, resp); // Overlay off.
		video_frame(20);

		repeat (4) next_cycle();
		if (uut.u_props.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			stop_with_failure("Bound assertions reported failures.");
		end
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
axil_pkg.sv
arcade_io_pkg.sv
game_buttons_if.sv
key_decode.sv
control_merge.sv
config_regs.sv
overlay_color.sv
arcade_io_top.sv
arcade_io_properties.sv
tb_arcade_io.sv
